// ==== snd_pkg.sv ====
package snd_pkg;

    // bus and audio widths
    typedef logic        [15:0] addr_t;     // sound cpu address
    typedef logic        [ 7:0] byte_t;     // bus data, latch, rom byte
    typedef logic        [15:0] pcm_addr_t; // {bank, offset}
    typedef logic signed [15:0] audio_t;
    typedef logic signed [ 7:0] pcm_smp_t;  // rom byte - 128
    typedef logic        [ 7:0] gain_t;     // 4.4 fixed point
    typedef logic        [ 2:0] rate_t;
    typedef logic        [ 3:0] bank_t;

    // command byte written to port 0x80
    typedef struct packed {
        logic  run;  // bit 7, 0 stops playback
        bank_t bank; // 4 KB bank select
        rate_t rate; // ticks every rate+1 cen_pcm
    } pcm_cmd_t;

    // strobes from the bus master, one cycle each
    typedef struct packed {
        logic  mem_rd;
        logic  io_rd;
        logic  io_wr;
        addr_t addr;
        byte_t wdata;
    } bus_req_t;

    typedef enum logic [1:0] {
        PCM_IDLE,
        PCM_WAIT,
        PCM_FETCH
    } pcm_state_t;

    localparam gain_t FM_GAIN    = 8'h08;     // 0.5
    localparam gain_t PCM_GAIN   = 8'h08;
    localparam byte_t CMD_PORT   = 8'h80;     // matched on A[7:6]
    localparam byte_t LATCH_PORT = 8'hc0;     // matched on A[7:6]
    localparam addr_t LATCH_MEM  = 16'he800;  // matched on A[15:11]
    localparam byte_t END_BYTE   = 8'hff;
    localparam byte_t OPEN_BUS   = 8'hff;     // nothing selected

endpackage

// ==== snd_bus_decode.sv ====
`timescale 1ns/100ps

module snd_bus_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  snd_pkg::bus_req_t req,
    input  snd_pkg::byte_t    latch,     // main cpu command
    input  logic              irqn,
    output snd_pkg::byte_t    rdata,
    output logic              ack,
    output logic              nmi_n,
    output snd_pkg::pcm_cmd_t pcm_cmd,
    output logic              cmd_wr
);

    logic latch_mem_hit;
    logic latch_io_hit;
    logic latch_rd;   // latch read this cycle, either space
    logic cmd_hit;    // io write to the pcm command port
    logic irqn_q;     // previous irqn
    logic irq_fall;

    assign latch_mem_hit = req.mem_rd && req.addr[15:11] == snd_pkg::LATCH_MEM[15:11];
    assign latch_io_hit  = req.io_rd && req.addr[7:6] == snd_pkg::LATCH_PORT[7:6];
    assign latch_rd      = latch_mem_hit || latch_io_hit;
    assign cmd_hit       = req.io_wr && req.addr[7:6] == snd_pkg::CMD_PORT[7:6]; // 80
    assign irq_fall      = irqn_q && !irqn;

    // read data and ack, one cycle after the strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= snd_pkg::OPEN_BUS;
            ack   <= 1'b0;
        end else begin
            ack <= latch_rd;
            if (req.mem_rd || req.io_rd) begin
                rdata <= latch_rd ? latch : snd_pkg::OPEN_BUS; // unmapped reads float high
            end
        end
    end

    // command register for the pcm channel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm_cmd <= '0;
            cmd_wr  <= 1'b0;
        end else begin
            cmd_wr <= cmd_hit;
            if (cmd_hit) begin
                pcm_cmd <= snd_pkg::pcm_cmd_t'(req.wdata);
            end
        end
    end

    // nmi flip-flop
    // falling irqn sets it, reading the latch clears it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irqn_q <= 1'b1;
            nmi_n  <= 1'b1;
        end else begin
            irqn_q <= irqn;
            if (irq_fall) begin
                nmi_n <= 1'b0;   // set has priority
            end else if (latch_rd) begin
                nmi_n <= 1'b1;
            end
        end
    end

    // the bus master never overlaps strobes
    a_one_strobe : assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({req.mem_rd, req.io_rd, req.io_wr}));

endmodule

// ==== pcm_rate_timer.sv ====
`timescale 1ns/100ps

module pcm_rate_timer (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           cen_pcm,
    input  logic           run,
    input  logic           start,
    input  snd_pkg::rate_t rate,
    output logic           tick
);

    snd_pkg::rate_t cnt;   // pulses left before the next tick

    // no tick in the reload cycle
    assign tick = run && cen_pcm && cnt == '0 && !start;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (start || tick) begin
            cnt <= rate;
        end else if (run && cen_pcm) begin
            cnt <= cnt - 1'b1;
        end
    end

    // start comes with the first run cycle, so a tick never lands there
    a_tick_run : assert property (@(posedge clk) disable iff (!arst_n)
        tick |-> $past(run));

endmodule

// ==== pcm_sample_fetch.sv ====
`timescale 1ns/100ps

module pcm_sample_fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  snd_pkg::bank_t     bank,
    input  logic               fetch,
    input  logic               silence,
    input  snd_pkg::byte_t     pcm_data,
    input  logic               pcm_ok,
    output snd_pkg::pcm_addr_t pcm_addr,
    output snd_pkg::pcm_smp_t  pcm_smp,
    output logic               fetch_done,
    output logic               at_end
);

    logic end_byte;
    logic last_ofs;   // offset 0xfff, bank exhausted

    assign end_byte   = pcm_data == snd_pkg::END_BYTE;
    assign last_ofs   = &pcm_addr[11:0];
    assign fetch_done = fetch && pcm_ok;   // pcm_ok outside a fetch is ignored
    assign at_end     = end_byte || last_ofs;

    // address counter, offset only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm_addr <= '0;
        end else if (start) begin
            pcm_addr <= {bank, 12'h000};   // bank base
        end else if (fetch_done) begin
            pcm_addr[11:0] <= pcm_addr[11:0] + 1'b1;
        end
    end

    // unsigned rom byte to signed sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm_smp <= '0;
        end else if (silence) begin
            pcm_smp <= '0;
        end else if (fetch_done) begin
            pcm_smp <= end_byte ? '0 : {~pcm_data[7], pcm_data[6:0]}; // -128
        end
    end

    a_addr_hold : assert property (@(posedge clk) disable iff (!arst_n)
        fetch && !pcm_ok ##1 fetch |-> $stable(pcm_addr));

endmodule

// ==== pcm_ctrl_fsm.sv ====
`timescale 1ns/100ps

module pcm_ctrl_fsm (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_wr,
    input  snd_pkg::pcm_cmd_t pcm_cmd,
    input  logic              tick,       // from rate timer
    input  logic              fetch_done, // byte accepted
    input  logic              at_end,
    output logic              run,
    output logic              start,
    output logic              fetch,      // drives pcm_cs
    output logic              silence
);

    snd_pkg::pcm_state_t state;
    snd_pkg::pcm_state_t next;

    always_comb begin
        next = state;
        if (cmd_wr) begin
            // a command wins over anything in flight
            next = pcm_cmd.run ? snd_pkg::PCM_WAIT : snd_pkg::PCM_IDLE;
        end else begin
            unique case (state)
                snd_pkg::PCM_IDLE:  next = snd_pkg::PCM_IDLE;
                snd_pkg::PCM_WAIT:  if (tick) next = snd_pkg::PCM_FETCH;
                snd_pkg::PCM_FETCH: begin
                    if (fetch_done) begin
                        next = at_end ? snd_pkg::PCM_IDLE : snd_pkg::PCM_WAIT;
                    end               // late ticks are lost here
                end
                default:            next = snd_pkg::PCM_IDLE;
            endcase
        end
    end

    // outputs registered from the next state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= snd_pkg::PCM_IDLE;
            run     <= 1'b0;
            fetch   <= 1'b0;
            start   <= 1'b0;
            silence <= 1'b0;
        end else begin
            state   <= next;
            run     <= next != snd_pkg::PCM_IDLE;
            fetch   <= next == snd_pkg::PCM_FETCH;
            start   <= cmd_wr && pcm_cmd.run;   // reload timer and address
            silence <= cmd_wr && !pcm_cmd.run;  // stop mutes at once
        end
    end

    // a late pcm_ok after a stop must not count as a byte
    a_done_in_fetch : assert property (@(posedge clk) disable iff (!arst_n)
        fetch_done |-> state == snd_pkg::PCM_FETCH);

endmodule

// ==== snd_mixer.sv ====
`timescale 1ns/100ps

module snd_mixer (
    input  logic              clk,
    input  logic              arst_n,
    input  snd_pkg::audio_t   fm_left,
    input  snd_pkg::audio_t   fm_right,
    input  snd_pkg::pcm_smp_t pcm_smp,
    output snd_pkg::audio_t   snd,
    output logic              peak
);

    logic signed [15:0] pcm_ext;  // pcm scaled to 16 bits
    logic signed [24:0] mul_l;
    logic signed [24:0] mul_r;
    logic signed [24:0] mul_p;
    logic signed [26:0] sum;      // room for three products
    logic signed [22:0] scaled;   // after the 4.4 shift
    logic               over;
    snd_pkg::audio_t    sat;

    assign pcm_ext = {pcm_smp, 8'h00};

    // gains with a zero sign bit
    assign mul_l = fm_left * $signed({1'b0, snd_pkg::FM_GAIN});
    assign mul_r = fm_right * $signed({1'b0, snd_pkg::FM_GAIN});
    assign mul_p = pcm_ext * $signed({1'b0, snd_pkg::PCM_GAIN});
    assign sum   = mul_l + mul_r + mul_p;

    assign scaled = sum[26:4];   // drop the fraction

    // top bits must all match the sign to fit in 16
    assign over = !(&scaled[22:15] || ~|scaled[22:15]);

    always_comb begin
        if (over) begin
            sat = scaled[22] ? 16'sh8000 : 16'sh7fff;   // clip to full scale
        end else begin
            sat = scaled[15:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd  <= '0;
            peak <= 1'b0;
        end else begin
            snd  <= sat;
            peak <= over;   // one cycle per clipped sample
        end
    end

endmodule

// ==== snd_top.sv ====
`timescale 1ns/100ps

module snd_top (
    input  logic               clk,
    input  logic               arst_n,
    // bus master side
    input  snd_pkg::bus_req_t  req,
    input  snd_pkg::byte_t     latch,
    input  logic               irqn,
    output snd_pkg::byte_t     rdata,
    output logic               ack,
    output logic               nmi_n,
    // pcm rom
    input  logic               cen_pcm,
    output snd_pkg::pcm_addr_t pcm_addr,
    output logic               pcm_cs,
    input  snd_pkg::byte_t     pcm_data,
    input  logic               pcm_ok,
    // audio
    input  snd_pkg::audio_t    fm_left,
    input  snd_pkg::audio_t    fm_right,
    output snd_pkg::audio_t    snd,
    output logic               peak
);

    snd_pkg::pcm_cmd_t pcm_cmd;
    snd_pkg::pcm_smp_t pcm_smp;
    logic              cmd_wr;
    logic              tick;
    logic              fetch_done;
    logic              at_end;
    logic              run;
    logic              start;
    logic              silence;

    snd_bus_decode u_decode (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .req     ( req     ),
        .latch   ( latch   ),
        .irqn    ( irqn    ),
        .rdata   ( rdata   ),
        .ack     ( ack     ),
        .nmi_n   ( nmi_n   ),
        .pcm_cmd ( pcm_cmd ),
        .cmd_wr  ( cmd_wr  )
    );

    pcm_ctrl_fsm u_fsm (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cmd_wr     ( cmd_wr     ),
        .pcm_cmd    ( pcm_cmd    ),
        .tick       ( tick       ),
        .fetch_done ( fetch_done ),
        .at_end     ( at_end     ),
        .run        ( run        ),
        .start      ( start      ),
        .fetch      ( pcm_cs     ),  // fetch request is the rom select
        .silence    ( silence    )
    );

    pcm_rate_timer u_timer (
        .clk     ( clk          ),
        .arst_n  ( arst_n       ),
        .cen_pcm ( cen_pcm      ),
        .run     ( run          ),
        .start   ( start        ),
        .rate    ( pcm_cmd.rate ),
        .tick    ( tick         )
    );

    pcm_sample_fetch u_fetch (
        .clk        ( clk          ),
        .arst_n     ( arst_n       ),
        .start      ( start        ),
        .bank       ( pcm_cmd.bank ),
        .fetch      ( pcm_cs       ),
        .silence    ( silence      ),
        .pcm_data   ( pcm_data     ),
        .pcm_ok     ( pcm_ok       ),
        .pcm_addr   ( pcm_addr     ),
        .pcm_smp    ( pcm_smp      ),
        .fetch_done ( fetch_done   ),
        .at_end     ( at_end       )
    );

    snd_mixer u_mixer (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .fm_left  ( fm_left  ),
        .fm_right ( fm_right ),
        .pcm_smp  ( pcm_smp  ),
        .snd      ( snd      ),
        .peak     ( peak     )
    );

endmodule

// ==== tb_snd.sv ====
`timescale 1ns/100ps

module tb_snd;

    // stimulus cycles per test, worst case
    localparam int LAT_CYC  = 160;
    localparam int NMI_CYC  = 200;
    localparam int PLAY_CYC = 2100;
    localparam int STOP_CYC = 400;
    localparam int MAX_CYC  = (LAT_CYC + NMI_CYC + PLAY_CYC + STOP_CYC) * 4 + 1000;

    logic               clk;
    logic               arst_n;
    snd_pkg::bus_req_t  req;
    snd_pkg::byte_t     latch;
    logic               irqn;
    snd_pkg::byte_t     rdata;
    logic               ack;
    logic               nmi_n;
    logic               cen_pcm  = 1'b0;
    snd_pkg::pcm_addr_t pcm_addr;
    logic               pcm_cs;
    snd_pkg::byte_t     pcm_data = '0;
    logic               pcm_ok   = 1'b0;
    snd_pkg::audio_t    fm_left;
    snd_pkg::audio_t    fm_right;
    snd_pkg::audio_t    snd;
    logic               peak;

    logic [31:0]        lfsr = 32'h74d4_1577;
    snd_pkg::byte_t     rom [0:65535];
    int                 rom_wait   = -1;   // -1 idle, else cycles to pcm_ok
    snd_pkg::pcm_smp_t  smp_model  = '0;   // sample as seen from the rom port
    snd_pkg::audio_t    exp_snd    = '0;
    logic               exp_peak   = 1'b0;
    snd_pkg::pcm_addr_t exp_addr   = '0;
    snd_pkg::rate_t     cur_rate   = '0;
    logic               cs_allowed = 1'b0; // playing, fetches may start
    logic               cs_prev    = 1'b0;
    logic               wr_q       = 1'b0;
    logic               sil_q      = 1'b0; // stop seen, sample clears next
    snd_pkg::pcm_cmd_t  cmd_q      = '0;
    int                 acc_count  = 0;    // bytes taken since start
    int                 end_count  = 0;
    int                 cen_cnt    = 0;    // cen pulses since last fetch start
    int                 cycles     = 0;
    int                 checks     = 0;
    int                 errors     = 0;
    int                 test_base  = 0;
    logic               mix_on     = 1'b0;

    snd_top uut (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .req      ( req      ),
        .latch    ( latch    ),
        .irqn     ( irqn     ),
        .rdata    ( rdata    ),
        .ack      ( ack      ),
        .nmi_n    ( nmi_n    ),
        .cen_pcm  ( cen_pcm  ),
        .pcm_addr ( pcm_addr ),
        .pcm_cs   ( pcm_cs   ),
        .pcm_data ( pcm_data ),
        .pcm_ok   ( pcm_ok   ),
        .fm_left  ( fm_left  ),
        .fm_right ( fm_right ),
        .snd      ( snd      ),
        .peak     ( peak     )
    );

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // gains of 0.5 on all inputs, pcm scaled by 256 first
    function automatic int mix_ref(input snd_pkg::audio_t l, input snd_pkg::audio_t r,
                                   input snd_pkg::pcm_smp_t p);
        return (int'(l) * 8 + int'(r) * 8 + int'(p) * 2048) >>> 4;
    endfunction

    task automatic check_byte(input snd_pkg::byte_t got, input snd_pkg::byte_t exp,
                              input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_audio(input snd_pkg::audio_t got, input snd_pkg::audio_t exp,
                               input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input snd_pkg::pcm_addr_t got, input snd_pkg::pcm_addr_t exp,
                              input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    task automatic test_done(input string name);
        $display("%-16s done, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // one read strobe, rdata and ack checked the cycle after
    task automatic do_read(input logic mem, input snd_pkg::addr_t a);
        snd_pkg::byte_t v;
        logic           hit;
        v   = snd_pkg::byte_t'(rnd(8));
        hit = mem ? (a[15:11] == 5'h1d) : (a[7:6] == 2'b11);   // 0xe800 or port 0xc0
        @(posedge clk);
        req.mem_rd <= mem;
        req.io_rd  <= !mem;
        req.addr   <= a;
        latch      <= v;
        @(posedge clk);
        req.mem_rd <= 1'b0;
        req.io_rd  <= 1'b0;
        @(negedge clk);
        check_byte(rdata, hit ? v : 8'hff, "rdata");
        check_bit(ack, hit, "ack");
        @(negedge clk);
        check_bit(ack, 1'b0, "ack");   // single cycle pulse
    endtask

    task automatic bus_write(input snd_pkg::byte_t d);
        @(posedge clk);
        req.io_wr <= 1'b1;
        req.addr  <= 16'h0080;   // pcm command port
        req.wdata <= d;
        @(posedge clk);
        req.io_wr <= 1'b0;
    endtask

    task automatic fm_random(input int n);
        repeat (n) begin
            @(posedge clk);
            fm_left  <= snd_pkg::audio_t'(rnd(16));
            fm_right <= snd_pkg::audio_t'(rnd(16));
        end
    endtask

    // play one bank to its end byte at offset 16+bank
    task automatic play(input snd_pkg::bank_t bank, input snd_pkg::rate_t rate);
        snd_pkg::pcm_cmd_t cmd;
        int                ends;
        cmd.run  = 1'b1;
        cmd.bank = bank;
        cmd.rate = rate;
        ends     = end_count;
        bus_write(snd_pkg::byte_t'(cmd));
        while (end_count == ends) @(posedge clk);
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_audio(snd, '0, "snd");
        check_bit(pcm_cs, 1'b0, "pcm_cs");
        check_addr(pcm_addr, {bank, 12'(17 + int'(bank))}, "pcm_addr");
        repeat (30) @(posedge clk);   // monitor flags any late fetch
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYC) begin
            $display("timeout after %0d cycles, a test never finished", MAX_CYC);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cen_pcm <= rnd(4) < 5;   // roughly one in three
        end
    end

    // pcm rom with 0 to 3 extra cycles of latency
    always @(posedge clk) begin
        pcm_ok <= 1'b0;
        if (!pcm_cs || pcm_ok) begin
            rom_wait <= -1;   // dropped or byte taken
        end else if (rom_wait < 0) begin
            rom_wait <= int'(rnd(2));
        end else if (rom_wait == 0) begin
            pcm_ok   <= 1'b1;
            pcm_data <= rom[pcm_addr];
        end else begin
            rom_wait <= rom_wait - 1;
        end
    end

    // reference model, fed from the ports only
    always @(posedge clk) begin : model
        int s;
        if (arst_n) begin
            s        = mix_ref(fm_left, fm_right, smp_model);
            exp_peak <= s > 32767 || s < -32768;
            if (s > 32767) begin
                exp_snd <= 16'sh7fff;
            end else if (s < -32768) begin
                exp_snd <= 16'sh8000;
            end else begin
                exp_snd <= snd_pkg::audio_t'(s);
            end
            if (pcm_cs && pcm_ok) begin   // byte accepted
                acc_count      <= acc_count + 1;
                exp_addr[11:0] <= exp_addr[11:0] + 12'd1;
                smp_model      <= (pcm_data == snd_pkg::END_BYTE) ? '0 :
                                  snd_pkg::pcm_smp_t'(pcm_data - 8'd128);
                if (pcm_data == snd_pkg::END_BYTE || exp_addr[11:0] == 12'hfff) begin
                    cs_allowed <= 1'b0;
                    end_count  <= end_count + 1;
                end
            end
            wr_q  <= req.io_wr && req.addr[7:6] == 2'b10;   // port 0x80
            cmd_q <= snd_pkg::pcm_cmd_t'(req.wdata);
            if (wr_q) begin   // command takes effect a cycle later
                cs_allowed <= cmd_q.run;
                if (cmd_q.run) begin
                    exp_addr  <= {cmd_q.bank, 12'h000};
                    cur_rate  <= cmd_q.rate;
                    acc_count <= 0;
                end
            end
            sil_q <= wr_q && !cmd_q.run;
            if (sil_q) begin   // stop mutes one cycle after the command
                smp_model <= '0;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            if (pcm_cs && !cs_prev) begin   // new fetch
                if (!cs_allowed) begin
                    report_error("pcm_cs rose while playback was stopped");
                end
                if (cen_cnt < int'(cur_rate) + 1) begin
                    report_error($sformatf("fetch started after only %0d cen_pcm pulses, rate %0d",
                                           cen_cnt, cur_rate));
                end
                cen_cnt = 0;
            end
            if (pcm_cs) begin
                check_addr(pcm_addr, exp_addr, "pcm_addr");   // held until pcm_ok
            end
            if (cen_pcm) begin
                cen_cnt++;
            end
            cs_prev = pcm_cs;
            if (mix_on) begin
                check_audio(snd, exp_snd, "snd");
                check_bit(peak, exp_peak, "peak");
            end
        end
    end

    initial begin
        snd_pkg::pcm_cmd_t cmd;
        snd_pkg::addr_t    a;
        snd_pkg::byte_t    b;
        logic              mem;
        logic              hit;
        req      = '0;
        latch    = '0;
        irqn     = 1'b1;
        fm_left  = '0;
        fm_right = '0;
        arst_n   = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            b = snd_pkg::byte_t'(rnd(8));
            if (b == snd_pkg::END_BYTE) b = 8'h7f;
            if (i % 4096 == 16 + i / 4096) b = snd_pkg::END_BYTE;
            rom[i] = b;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        mix_on = 1'b1;

        repeat (40) begin
            mem = rnd(1) != 0;
            hit = rnd(1) != 0;
            a   = snd_pkg::addr_t'(rnd(16));
            if (mem) begin
                a[15:11] = hit ? 5'h1d : ((a[15:11] == 5'h1d) ? 5'h1c : a[15:11]);
            end else begin
                a[7:6] = hit ? 2'b11 : {1'b0, a[6]};
            end
            do_read(mem, a);
        end
        test_done("latch reads");

        check_bit(nmi_n, 1'b1, "nmi_n");
        repeat (4) begin
            fm_random(3);
            @(posedge clk);
            irqn <= 1'b0;
            fm_random(3);
            @(negedge clk);
            check_bit(nmi_n, 1'b0, "nmi_n");
            do_read(1'b0, 16'h0040);   // not the latch, stays set
            check_bit(nmi_n, 1'b0, "nmi_n");
            do_read(1'b1, 16'he800);
            check_bit(nmi_n, 1'b1, "nmi_n");
            @(posedge clk);
            irqn <= 1'b1;
        end
        test_done("nmi and fm mix");

        @(posedge clk);
        fm_left  <= '0;
        fm_right <= '0;
        repeat (2) play(snd_pkg::bank_t'(rnd(4)), snd_pkg::rate_t'(rnd(3)));
        test_done("pcm playback");

        cmd.run  = 1'b1;
        cmd.bank = snd_pkg::bank_t'(rnd(4));
        cmd.rate = '0;
        bus_write(snd_pkg::byte_t'(cmd));
        fm_random(2);   // model clears acc_count as the command lands
        while (acc_count < 6) fm_random(1);   // loud fm, peak gets exercised
        @(posedge clk);
        fm_left  <= '0;
        fm_right <= '0;
        cmd.run  = 1'b0;
        bus_write(snd_pkg::byte_t'(cmd));
        repeat (6) @(posedge clk);
        @(negedge clk);
        check_audio(snd, '0, "snd");
        check_bit(peak, 1'b0, "peak");
        check_bit(pcm_cs, 1'b0, "pcm_cs");
        repeat (40) @(posedge clk);
        test_done("stop command");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
snd_pkg.sv
snd_bus_decode.sv
pcm_rate_timer.sv
pcm_sample_fetch.sv
pcm_ctrl_fsm.sv
snd_mixer.sv
snd_top.sv
tb_snd.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_snd -f sources.f -o sim_snd
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_snd > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
